// ==== Makefile ====
# Verilator simulation of the L2 switch testbench

VERILATOR ?= verilator
TOP       ?= tb_l2_switch
FILELIST  ?= l2_switch_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the log decides the result, the simulator exit code does not
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/egress_scheduler.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "l2_switch_settings.svh"

module egress_scheduler (
        input  wire                             aclk,
        input  wire                             aresetn,
        input  wire                             dec_valid_i,
        input  wire l2_switch_pkg::port_mask_t  dec_mask_i,
        input  wire l2_switch_pkg::byte_t       buf_data_i,
        input  wire                             buf_last_i,
        input  wire                             buf_not_empty_i,
        output logic                            buf_rd_en_o,
        output l2_switch_pkg::byte_t            m_tdata_o,
        output logic                            m_tvalid_o,
        output logic                            m_tlast_o,
        output l2_switch_pkg::port_mask_t       m_port_mask_o,
        input  wire                             m_tready_i
);

        import l2_switch_pkg::*;

        localparam int QW = $clog2(`L2_DEC_DEPTH);

        egress_state_t  state;
        // decision queue, one mask per frame in arrival order
        port_mask_t     q_mem [`L2_DEC_DEPTH];
        logic [QW-1:0]  q_wr;
        logic [QW-1:0]  q_rd;
        logic [QW:0]    q_count;
        logic           q_pop;
        // last byte of the frame already fetched
        logic           fetch_done;

        assign q_pop = (state == IDLE) && (q_count != '0) && buf_not_empty_i;

        // ----------------------------------------
        // buffer read request
        // ----------------------------------------
        always_comb
        begin
                case (state)
                SEND:    buf_rd_en_o = (!m_tvalid_o || m_tready_i) && buf_not_empty_i &&
                                       !fetch_done;
                DISCARD: buf_rd_en_o = buf_not_empty_i;
                default: buf_rd_en_o = 1'b0;
                endcase
        end

        always_ff @(posedge aclk)
        begin
                if (!aresetn)
                begin
                        state      <= IDLE;
                        q_wr       <= '0;
                        q_rd       <= '0;
                        q_count    <= '0;
                        m_tvalid_o <= 1'b0;
                        fetch_done <= 1'b0;
                end
                else
                begin
                        if (dec_valid_i)
                                q_wr <= q_wr + 1'b1;
                        if (q_pop)
                                q_rd <= q_rd + 1'b1;
                        if (dec_valid_i && !q_pop)
                                q_count <= q_count + 1'b1;
                        else if (q_pop && !dec_valid_i)
                                q_count <= q_count - 1'b1;

                        case (state)
                        IDLE:
                        begin
                                // zero mask means filtered
                                if (q_pop)
                                        state <= (q_mem[q_rd] != '0) ? SEND : DISCARD;
                        end
                        SEND:
                        begin
                                if (buf_rd_en_o)
                                begin
                                        m_tvalid_o <= 1'b1;
                                        if (buf_last_i)
                                                fetch_done <= 1'b1;
                                end
                                else if (m_tready_i)
                                begin
                                        m_tvalid_o <= 1'b0;
                                end
                                if (m_tvalid_o && m_tready_i && m_tlast_o)
                                begin
                                        state      <= IDLE;
                                        fetch_done <= 1'b0;
                                end
                        end
                        DISCARD:
                        begin
                                if (buf_rd_en_o && buf_last_i)
                                        state <= IDLE;
                        end
                        default:
                                state <= IDLE;
                        endcase
                end
        end

        // payload side
        always_ff @(posedge aclk)
        begin
                if (dec_valid_i)
                        q_mem[q_wr] <= dec_mask_i;
                if (q_pop)
                        m_port_mask_o <= q_mem[q_rd];
                if (state == SEND && buf_rd_en_o)
                begin
                        m_tdata_o <= buf_data_i;
                        m_tlast_o <= buf_last_i;
                end
        end

        a_queue_room: assert property (@(posedge aclk) disable iff (!aresetn)
                dec_valid_i |-> (q_count < (QW+1)'(`L2_DEC_DEPTH)) || q_pop);
        a_stall_hold: assert property (@(posedge aclk) disable iff (!aresetn)
                m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) &&
                $stable(m_port_mask_o));

endmodule

`default_nettype wire

// ==== hw/frame_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "l2_switch_settings.svh"

module frame_buffer (
        input  wire                         aclk,
        input  wire                         aresetn,
        input  wire l2_switch_pkg::byte_t   wr_data_i,
        input  wire                         wr_last_i,
        input  wire                         wr_en_i,
        output logic                        full_o,
        input  wire                         rd_en_i,
        output l2_switch_pkg::byte_t        rd_data_o,
        output logic                        rd_last_o,
        output logic                        not_empty_o
);

        import l2_switch_pkg::*;

        localparam int AW = $clog2(`L2_FIFO_DEPTH);

        // byte storage with end-of-frame flag alongside
        byte_t          mem_data [`L2_FIFO_DEPTH];
        logic           mem_last [`L2_FIFO_DEPTH];
        logic [AW-1:0]  wr_ptr;
        logic [AW-1:0]  rd_ptr;
        logic [AW:0]    count;
        logic           do_wr;
        logic           do_rd;

        assign do_wr = wr_en_i && !full_o;
        assign do_rd = rd_en_i && not_empty_o;

        assign full_o      = (count == (AW+1)'(`L2_FIFO_DEPTH));
        assign not_empty_o = (count != '0);

        // head of the queue, seen without a read
        assign rd_data_o = mem_data[rd_ptr];
        assign rd_last_o = mem_last[rd_ptr];

        always_ff @(posedge aclk)
        begin
                if (do_wr)
                begin
                        mem_data[wr_ptr] <= wr_data_i;
                        mem_last[wr_ptr] <= wr_last_i;
                end
        end

        // pointers wrap on their own width
        always_ff @(posedge aclk)
        begin
                if (!aresetn)
                begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end
                else
                begin
                        if (do_wr)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (do_rd)
                                rd_ptr <= rd_ptr + 1'b1;
                        if (do_wr && !do_rd)
                                count <= count + 1'b1;
                        else if (do_rd && !do_wr)
                                count <= count - 1'b1;
                end
        end

        // callers must respect full and empty
        a_no_write_full: assert property (@(posedge aclk) disable iff (!aresetn)
                wr_en_i |-> !full_o);
        a_no_read_empty: assert property (@(posedge aclk) disable iff (!aresetn)
                rd_en_i |-> not_empty_o);

endmodule

`default_nettype wire

// ==== hw/l2_switch_pkg.sv ====
`default_nettype none

`include "l2_switch_settings.svh"

package l2_switch_pkg;

        // stream and header fields
        typedef logic [7:0] byte_t;
        typedef logic [47:0] mac_addr_t;

        // ----------------------------------------
        // port numbering, one mask bit per port
        // ----------------------------------------
        typedef logic [$clog2(`L2_NUM_PORTS)-1:0] port_id_t;
        typedef logic [`L2_NUM_PORTS-1:0] port_mask_t;

        // header parser
        typedef enum logic {
                IN_HEADER,
                IN_PAYLOAD
        } parse_state_t;

        // egress scheduler
        typedef enum logic [1:0] {
                IDLE,
                SEND,
                DISCARD
        } egress_state_t;

endpackage

`default_nettype wire

// ==== hw/l2_switch_settings.svh ====
`ifndef L2_SWITCH_SETTINGS_SVH
`define L2_SWITCH_SETTINGS_SVH

// switch geometry
`define L2_NUM_PORTS 4
`define L2_TABLE_DEPTH 8

// ----------------------------------------
// buffering
// ----------------------------------------
`define L2_FIFO_DEPTH 256
// most minimum-size frames the byte buffer can hold
`define L2_DEC_DEPTH 16
`define L2_MIN_FRAME 16

`endif

// ==== hw/l2_switch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_switch_top (
        input  wire                             aclk,
        input  wire                             aresetn,
        // merged ingress from all ports
        input  wire l2_switch_pkg::byte_t       s_tdata_i,
        input  wire                             s_tvalid_i,
        input  wire                             s_tlast_i,
        input  wire l2_switch_pkg::port_id_t    s_port_i,
        output logic                            s_tready_o,
        // egress with destination mask
        output l2_switch_pkg::byte_t            m_tdata_o,
        output logic                            m_tvalid_o,
        output logic                            m_tlast_o,
        output l2_switch_pkg::port_mask_t       m_port_mask_o,
        input  wire                             m_tready_i
);

        import l2_switch_pkg::*;

        logic           buf_full;
        logic           accept;
        byte_t          buf_data;
        logic           buf_last;
        logic           buf_not_empty;
        logic           buf_rd_en;

        logic           hdr_valid;
        mac_addr_t      hdr_dst_mac;
        mac_addr_t      hdr_src_mac;
        port_id_t       hdr_src_port;

        logic           dec_valid;
        port_mask_t     dec_mask;

        assign s_tready_o = !buf_full;
        assign accept     = s_tvalid_i && !buf_full;

        // ----------------------------------------
        // data path and decision path side by side
        // ----------------------------------------
        frame_buffer u_frame_buffer (
                .aclk        (aclk),
                .aresetn     (aresetn),
                .wr_data_i   (s_tdata_i),
                .wr_last_i   (s_tlast_i),
                .wr_en_i     (accept),
                .full_o      (buf_full),
                .rd_en_i     (buf_rd_en),
                .rd_data_o   (buf_data),
                .rd_last_o   (buf_last),
                .not_empty_o (buf_not_empty)
        );

        mac_header_parser u_parser (
                .aclk        (aclk),
                .aresetn     (aresetn),
                .beat_i      (accept),
                .data_i      (s_tdata_i),
                .last_i      (s_tlast_i),
                .port_i      (s_port_i),
                .hdr_valid_o (hdr_valid),
                .dst_mac_o   (hdr_dst_mac),
                .src_mac_o   (hdr_src_mac),
                .src_port_o  (hdr_src_port)
        );

        mac_forward_table u_fwd_table (
                .aclk        (aclk),
                .aresetn     (aresetn),
                .hdr_valid_i (hdr_valid),
                .dst_mac_i   (hdr_dst_mac),
                .src_mac_i   (hdr_src_mac),
                .src_port_i  (hdr_src_port),
                .dec_valid_o (dec_valid),
                .dec_mask_o  (dec_mask)
        );

        // pairs each decision with its buffered frame
        egress_scheduler u_scheduler (
                .aclk            (aclk),
                .aresetn         (aresetn),
                .dec_valid_i     (dec_valid),
                .dec_mask_i      (dec_mask),
                .buf_data_i      (buf_data),
                .buf_last_i      (buf_last),
                .buf_not_empty_i (buf_not_empty),
                .buf_rd_en_o     (buf_rd_en),
                .m_tdata_o       (m_tdata_o),
                .m_tvalid_o      (m_tvalid_o),
                .m_tlast_o       (m_tlast_o),
                .m_port_mask_o   (m_port_mask_o),
                .m_tready_i      (m_tready_i)
        );

endmodule

`default_nettype wire

// ==== hw/mac_forward_table.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "l2_switch_settings.svh"

module mac_forward_table (
        input  wire                           aclk,
        input  wire                           aresetn,
        input  wire                           hdr_valid_i,
        input  wire l2_switch_pkg::mac_addr_t dst_mac_i,
        input  wire l2_switch_pkg::mac_addr_t src_mac_i,
        input  wire l2_switch_pkg::port_id_t  src_port_i,
        output logic                          dec_valid_o,
        output l2_switch_pkg::port_mask_t     dec_mask_o
);

        import l2_switch_pkg::*;

        localparam int IW = $clog2(`L2_TABLE_DEPTH);

        logic [`L2_TABLE_DEPTH-1:0] tbl_valid;
        mac_addr_t      tbl_mac [`L2_TABLE_DEPTH];
        port_id_t       tbl_port [`L2_TABLE_DEPTH];
        // next entry to evict, oldest insertion
        logic [IW-1:0]  repl_ptr;

        logic           dst_hit;
        port_id_t       dst_port;
        logic           src_hit;
        logic [IW-1:0]  src_idx;
        logic           learn;
        port_mask_t     mask;

        // ----------------------------------------
        // parallel search, pre-learn contents
        // ----------------------------------------
        always_comb
        begin
                dst_hit  = 1'b0;
                dst_port = '0;
                src_hit  = 1'b0;
                src_idx  = '0;
                for (int i = 0; i < `L2_TABLE_DEPTH; i++)
                begin
                        if (tbl_valid[i] && tbl_mac[i] == dst_mac_i)
                        begin
                                dst_hit  = 1'b1;
                                dst_port = tbl_port[i];
                        end
                        if (tbl_valid[i] && tbl_mac[i] == src_mac_i)
                        begin
                                src_hit = 1'b1;
                                src_idx = IW'(i);
                        end
                end
        end

        // group bit is bit 0 of the first byte
        always_comb
        begin
                if (dst_mac_i[40] || !dst_hit)
                        mask = ~(port_mask_t'(1) << src_port_i);
                else if (dst_port == src_port_i)
                        mask = '0;
                else
                        mask = port_mask_t'(1) << dst_port;
        end

        // multicast sources are never learned
        assign learn = hdr_valid_i && !src_mac_i[40];

        always_ff @(posedge aclk)
        begin
                if (!aresetn)
                begin
                        tbl_valid   <= '0;
                        repl_ptr    <= '0;
                        dec_valid_o <= 1'b0;
                end
                else
                begin
                        dec_valid_o <= hdr_valid_i;
                        if (learn && !src_hit)
                        begin
                                tbl_valid[repl_ptr] <= 1'b1;
                                repl_ptr            <= repl_ptr + 1'b1;
                        end
                end
        end

        always_ff @(posedge aclk)
        begin
                if (hdr_valid_i)
                        dec_mask_o <= mask;
                if (learn)
                begin
                        // known station just refreshes its port
                        if (src_hit)
                        begin
                                tbl_port[src_idx] <= src_port_i;
                        end
                        else
                        begin
                                tbl_mac[repl_ptr]  <= src_mac_i;
                                tbl_port[repl_ptr] <= src_port_i;
                        end
                end
        end

        a_no_hairpin: assert property (@(posedge aclk) disable iff (!aresetn)
                dec_valid_o && $onehot(dec_mask_o) |-> !dec_mask_o[$past(src_port_i)]);

endmodule

`default_nettype wire

// ==== hw/mac_header_parser.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "l2_switch_settings.svh"

module mac_header_parser (
        input  wire                         aclk,
        input  wire                         aresetn,
        input  wire                         beat_i,
        input  wire l2_switch_pkg::byte_t   data_i,
        input  wire                         last_i,
        input  wire l2_switch_pkg::port_id_t port_i,
        output logic                        hdr_valid_o,
        output l2_switch_pkg::mac_addr_t    dst_mac_o,
        output l2_switch_pkg::mac_addr_t    src_mac_o,
        output l2_switch_pkg::port_id_t     src_port_o
);

        import l2_switch_pkg::*;

        localparam int CW = $clog2(`L2_MIN_FRAME);
        localparam logic [CW-1:0] CNT_MAX = CW'(`L2_MIN_FRAME - 1);
        localparam logic [CW-1:0] HDR_LAST = CW'(11);

        parse_state_t   state;
        // saturates once past the minimum frame length
        logic [CW-1:0]  byte_cnt;

        // ----------------------------------------
        // frame position tracking
        // ----------------------------------------
        always_ff @(posedge aclk)
        begin
                if (!aresetn)
                begin
                        state       <= IN_HEADER;
                        byte_cnt    <= '0;
                        hdr_valid_o <= 1'b0;
                end
                else
                begin
                        hdr_valid_o <= 1'b0;
                        if (beat_i)
                        begin
                                if (state == IN_HEADER && byte_cnt == HDR_LAST)
                                begin
                                        state       <= IN_PAYLOAD;
                                        hdr_valid_o <= 1'b1;
                                end
                                if (last_i)
                                begin
                                        state    <= IN_HEADER;
                                        byte_cnt <= '0;
                                end
                                else if (byte_cnt != CNT_MAX)
                                begin
                                        byte_cnt <= byte_cnt + 1'b1;
                                end
                        end
                end
        end

        // address capture, first byte on the wire ends up as msb
        always_ff @(posedge aclk)
        begin
                if (beat_i && state == IN_HEADER)
                begin
                        if (byte_cnt == '0)
                                src_port_o <= port_i;
                        if (byte_cnt < CW'(6))
                                dst_mac_o <= {dst_mac_o[39:0], data_i};
                        else
                                src_mac_o <= {src_mac_o[39:0], data_i};
                end
        end

        // runt frames would break the decision queue sizing
        a_min_frame: assert property (@(posedge aclk) disable iff (!aresetn)
                beat_i && last_i |-> byte_cnt == CNT_MAX);

endmodule

`default_nettype wire

// ==== l2_switch_top.f ====
+incdir+hw
hw/l2_switch_pkg.sv
hw/frame_buffer.sv
hw/mac_header_parser.sv
hw/mac_forward_table.sv
hw/egress_scheduler.sv
hw/l2_switch_top.sv
sim/tb_l2_switch.sv

// ==== sim/tb_l2_switch.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_l2_switch;

        localparam int TBL_DEPTH   = 8;
        localparam int MAX_LEN     = 64;
        localparam int READY_LIMIT = 2000;
        localparam int DRAIN_LIMIT = 5000;
        localparam logic [47:0] BCAST = 48'hffff_ffff_ffff;
        localparam logic [47:0] MCAST = 48'h0300_5e00_0001;

        logic           aclk;
        logic           aresetn;
        logic [7:0]     s_tdata_i;
        logic           s_tvalid_i;
        logic           s_tlast_i;
        logic [1:0]     s_port_i;
        logic           s_tready_o;
        logic [7:0]     m_tdata_o;
        logic           m_tvalid_o;
        logic           m_tlast_o;
        logic [3:0]     m_port_mask_o;
        logic           m_tready_i = 1'b1;
        logic           rand_ready = 1'b0;

        // expected egress bytes as {mask, last, data}, consumed by rx_count
        logic [12:0]    exp_q [$];
        int             rx_count = 0;
        logic           exp_avail = 1'b0;
        logic [12:0]    exp_head = '0;
        logic           xfer;

        // reference learning table
        logic           mdl_valid [TBL_DEPTH];
        logic [47:0]    mdl_mac [TBL_DEPTH];
        logic [1:0]     mdl_port [TBL_DEPTH];
        int             mdl_repl;

        string          test_name = "reset";
        int             err_cnt = 0;
        int             err_start;
        int             pass_cnt = 0;
        int             fail_cnt = 0;

        l2_switch_top DUT (
                .aclk          (aclk),
                .aresetn       (aresetn),
                .s_tdata_i     (s_tdata_i),
                .s_tvalid_i    (s_tvalid_i),
                .s_tlast_i     (s_tlast_i),
                .s_port_i      (s_port_i),
                .s_tready_o    (s_tready_o),
                .m_tdata_o     (m_tdata_o),
                .m_tvalid_o    (m_tvalid_o),
                .m_tlast_o     (m_tlast_o),
                .m_port_mask_o (m_port_mask_o),
                .m_tready_i    (m_tready_i)
        );

        initial
        begin
                aclk = 1'b0;
                forever #5 aclk = ~aclk;
        end

        always @(negedge aclk)
        begin
                if (rand_ready)
                        m_tready_i = ($urandom % 4) != 0;
                else
                        m_tready_i = 1'b1;
        end

        // ----------------------------------------
        // egress checking
        // ----------------------------------------
        assign xfer = m_tvalid_o && m_tready_i;

        // head of the expected stream, refreshed every edge
        always @(posedge aclk)
        begin
                if (xfer && exp_avail)
                        rx_count = rx_count + 1;
                exp_avail = rx_count < exp_q.size();
                exp_head  = exp_avail ? exp_q[rx_count] : '0;
        end

        a_expected: assert property (@(posedge aclk) disable iff (!aresetn)
                xfer |-> exp_avail)
        else
        begin
                err_cnt++;
                $display("%s: egress byte %02h arrived while no byte was expected",
                         test_name, $sampled(m_tdata_o));
        end

        a_data: assert property (@(posedge aclk) disable iff (!aresetn)
                xfer && exp_avail |-> m_tdata_o == exp_head[7:0])
        else
        begin
                err_cnt++;
                $display("MISMATCH %s data expected %02h actual %02h", test_name,
                         $sampled(exp_head[7:0]), $sampled(m_tdata_o));
        end

        a_last: assert property (@(posedge aclk) disable iff (!aresetn)
                xfer && exp_avail |-> m_tlast_o == exp_head[8])
        else
        begin
                err_cnt++;
                $display("MISMATCH %s last expected %0b actual %0b", test_name,
                         $sampled(exp_head[8]), $sampled(m_tlast_o));
        end

        a_mask: assert property (@(posedge aclk) disable iff (!aresetn)
                xfer && exp_avail |-> m_port_mask_o == exp_head[12:9])
        else
        begin
                err_cnt++;
                $display("MISMATCH %s mask expected %04b actual %04b", test_name,
                         $sampled(exp_head[12:9]), $sampled(m_port_mask_o));
        end

        // locally administered unicast address
        function automatic logic [47:0] station(input logic [7:0] id);
                return {8'h02, 32'h0, id};
        endfunction

        function automatic int rand_len();
                return 16 + int'($urandom % 49);
        endfunction

        task automatic stop_on_timeout(input string what);
                $display("timeout in %s: %s", test_name, what);
                $display("** FAIL **");
                $finish;
        endtask

        // lookup on the old contents, then learn
        task automatic forward_model(input logic [47:0] dst, input logic [47:0] src,
                                     input logic [1:0] port, output logic [3:0] mask);
                logic           dst_found;
                logic [1:0]     dst_port;
                logic           src_found;
                int             src_slot;
                dst_found = 1'b0;
                dst_port  = '0;
                src_found = 1'b0;
                src_slot  = 0;
                for (int i = 0; i < TBL_DEPTH; i++)
                begin
                        if (mdl_valid[i] && mdl_mac[i] == dst)
                        begin
                                dst_found = 1'b1;
                                dst_port  = mdl_port[i];
                        end
                        if (mdl_valid[i] && mdl_mac[i] == src)
                        begin
                                src_found = 1'b1;
                                src_slot  = i;
                        end
                end
                if (dst[40] || !dst_found)
                        mask = ~(4'b0001 << port);
                else if (dst_port == port)
                        mask = 4'b0000;
                else
                        mask = 4'b0001 << dst_port;
                if (!src[40] && src_found)
                begin
                        mdl_port[src_slot] = port;
                end
                else if (!src[40])
                begin
                        mdl_valid[mdl_repl] = 1'b1;
                        mdl_mac[mdl_repl]   = src;
                        mdl_port[mdl_repl]  = port;
                        mdl_repl            = (mdl_repl + 1) % TBL_DEPTH;
                end
        endtask

        // called and returns on a falling edge
        task automatic send_frame(input logic [1:0] port, input logic [47:0] dst,
                                  input logic [47:0] src, input int len);
                logic [7:0]     fbytes [MAX_LEN];
                logic [3:0]     mask;
                int             wait_cnt;
                for (int i = 0; i < len; i++)
                begin
                        if (i < 6)
                                fbytes[i] = dst[47 - 8*i -: 8];
                        else if (i < 12)
                                fbytes[i] = src[47 - 8*(i-6) -: 8];
                        else
                                fbytes[i] = 8'($urandom);
                end
                forward_model(dst, src, port, mask);
                // filtered frames expect nothing
                if (mask != 4'b0000)
                begin
                        for (int i = 0; i < len; i++)
                                exp_q.push_back({mask, (i == len - 1), fbytes[i]});
                end
                for (int i = 0; i < len; i++)
                begin
                        s_tdata_i  = fbytes[i];
                        s_tlast_i  = (i == len - 1);
                        s_port_i   = port;
                        s_tvalid_i = 1'b1;
                        wait_cnt   = 0;
                        while (!s_tready_o)
                        begin
                                @(negedge aclk);
                                wait_cnt++;
                                if (wait_cnt > READY_LIMIT)
                                        stop_on_timeout("ingress never became ready");
                        end
                        @(negedge aclk);
                end
                s_tvalid_i = 1'b0;
                s_tlast_i  = 1'b0;
        endtask

        task automatic start_test(input string name);
                test_name = name;
                err_start = err_cnt;
        endtask

        task automatic finish_test();
                int cnt;
                cnt = 0;
                while (rx_count != exp_q.size() || m_tvalid_o)
                begin
                        @(negedge aclk);
                        cnt++;
                        if (cnt > DRAIN_LIMIT)
                                stop_on_timeout("expected egress bytes never arrived");
                end
                if (err_cnt == err_start)
                begin
                        pass_cnt++;
                        $display("test %s passed", test_name);
                end
                else
                begin
                        fail_cnt++;
                        $display("test %s failed with %0d errors", test_name,
                                 err_cnt - err_start);
                end
        endtask

        initial
        begin
                logic [7:0] dst_id;
                void'($urandom(32'hc605_874a));
                aresetn    = 1'b0;
                s_tdata_i  = '0;
                s_tvalid_i = 1'b0;
                s_tlast_i  = 1'b0;
                s_port_i   = '0;
                mdl_repl   = 0;
                for (int i = 0; i < TBL_DEPTH; i++)
                        mdl_valid[i] = 1'b0;
                repeat (5) @(posedge aclk);
                @(negedge aclk);
                aresetn = 1'b1;
                @(negedge aclk);

                start_test("flood_unknown");
                send_frame(2'd2, station(8'h0a), station(8'h0b), rand_len());
                finish_test();

                start_test("learned_unicast");
                send_frame(2'd1, station(8'h0d), station(8'h0c), rand_len());
                send_frame(2'd3, station(8'h0c), station(8'h0e), rand_len());
                finish_test();

                start_test("filter_same_port");
                send_frame(2'd3, station(8'h0e), station(8'h0f), rand_len());
                send_frame(2'd0, station(8'h0c), station(8'h10), rand_len());
                finish_test();

                // group addresses used as sources must stay out of the table
                start_test("broadcast_flood");
                send_frame(2'd0, station(8'h0c), BCAST, rand_len());
                send_frame(2'd1, BCAST, station(8'h0c), rand_len());
                send_frame(2'd2, station(8'h0b), MCAST, rand_len());
                send_frame(2'd2, MCAST, station(8'h0b), rand_len());
                // three fresh sources fill the table
                // station 0b survives only if no group source took a slot
                for (int n = 0; n < 3; n++)
                        send_frame(2'd3, BCAST, station(8'h20 + 8'(n)), rand_len());
                send_frame(2'd0, station(8'h0b), station(8'h10), rand_len());
                finish_test();

                start_test("random_backpressure");
                rand_ready = 1'b1;
                for (int n = 0; n < 24; n++)
                begin
                        dst_id = 8'($urandom % 8);
                        send_frame(2'($urandom), (dst_id == 0) ? BCAST : station(8'h50 + dst_id),
                                   station(8'h51 + 8'($urandom % 6)), rand_len());
                end
                finish_test();
                rand_ready = 1'b0;

                // nine fresh sources push the first one out
                start_test("evict_and_move");
                for (int n = 0; n < 9; n++)
                        send_frame(2'd1, BCAST, station(8'h80 + 8'(n)), rand_len());
                send_frame(2'd2, station(8'h80), station(8'h86), rand_len());
                send_frame(2'd3, BCAST, station(8'h85), rand_len());
                send_frame(2'd0, station(8'h85), station(8'h84), rand_len());
                finish_test();

                $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
                if (fail_cnt == 0)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

endmodule

`default_nettype wire
